/* compile.f */
+incdir+.
pci_target_pkg.sv
pci_address_decoder.sv
delayed_read_tracker.sv
response_builder.sv
pci_target_top.sv
tb_pci_target.sv

/* delayed_read_tracker.sv */
// Delayed read tracker: latches the read address, times its discard and spots colliding writes
`default_nettype none
`timescale 1ns/1ps
`include "pci_target_settings.svh"

module delayed_read_tracker
  import pci_target_pkg::*;
(
  input  logic        pci_clk,
  input  logic        pci_reset_comb,
  input  addr_phase_t addr_phase,
  output dr_event_t   dr_event,
  output logic        delayed_read_in_progress
);

  // Counter sized to hold the whole discard interval
  localparam int unsigned DISCARD_W = $clog2(`TARGET_DISCARD_CYCLES + 1);
  localparam logic [DISCARD_W-1:0] DISCARD_LOAD = DISCARD_W'(`TARGET_DISCARD_CYCLES - 1);

  // Width of a prefetch block number
  localparam int unsigned BLOCK_W = 32 - `PCI_COLLISION_LSB;

  // Block number of the delayed read and the block just after it
  logic [31:`PCI_COLLISION_LSB] dr_block;
  logic [31:`PCI_COLLISION_LSB] dr_block_next;
  logic [31:`PCI_COLLISION_LSB] write_block;

  logic [DISCARD_W-1:0] discard_count;

  logic read_start;
  logic block_match;
  logic collision_hit;
  logic timeout_hit;

  // ==========================================================
  // Event detect
  // ==========================================================

  // Only one delayed read is tracked, later reads leave it alone
  assign read_start = addr_phase.valid & addr_phase.is_read & ~delayed_read_in_progress;

  assign write_block   = addr_phase.address[31:`PCI_COLLISION_LSB];
  assign dr_block_next = dr_block + BLOCK_W'(1);

  // Prefetch may have run into the following block, so both are guarded
  assign block_match = (write_block == dr_block) | (write_block == dr_block_next);

  assign collision_hit = addr_phase.valid & addr_phase.is_write
                         & delayed_read_in_progress & block_match;

  // A collision in the last cycle wins, the read is restarted instead of discarded
  assign timeout_hit = delayed_read_in_progress & (discard_count == '0) & ~collision_hit;

  // ==========================================================
  // Tracker state
  // ==========================================================

  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      delayed_read_in_progress <= 1'b0;
      discard_count            <= '0;
      dr_event                 <= '0;
    end
    else
    begin
      dr_event.discarded <= timeout_hit;
      dr_event.collision <= collision_hit;
      if (read_start)
      begin
        // In-progress stays up for exactly the discard interval unless a write hits
        delayed_read_in_progress <= 1'b1;
        discard_count            <= DISCARD_LOAD;
      end
      else if (collision_hit | timeout_hit)
      begin
        delayed_read_in_progress <= 1'b0;
      end
      else if (delayed_read_in_progress)
      begin
        discard_count <= discard_count - DISCARD_W'(1);
      end
    end
  end

  // Latched block of the read being served
  always_ff @(posedge pci_clk)
  begin
    if (read_start)
    begin
      dr_block <= addr_phase.address[31:`PCI_COLLISION_LSB];
    end
  end

  // ==========================================================
  // Checks
  // ==========================================================

  // The two ways of ending a delayed read are exclusive
  a_events_exclusive : assert property (
    @(posedge pci_clk) disable iff (pci_reset_comb)
    !(dr_event.discarded && dr_event.collision)
  );

  // Each event ends a delayed read that was running in the cycle before
  a_event_ends_read : assert property (
    @(posedge pci_clk) disable iff (pci_reset_comb)
    (dr_event.discarded || dr_event.collision)
      |-> ($past(delayed_read_in_progress) && !delayed_read_in_progress)
  );

endmodule

`default_nettype wire

/* pci_address_decoder.sv */
// PCI address decoder: finds the address phase, classifies memory commands, matches the BAR
`default_nettype none
`timescale 1ns/1ps
`include "pci_target_settings.svh"

module pci_address_decoder
  import pci_target_pkg::*;
(
  input  logic                          pci_clk,
  input  logic                          pci_reset_comb,
  input  logic                          pci_frame_in_prev,
  input  logic [31:0]                   pci_ad_in_prev,
  input  logic [3:0]                    pci_cbe_l_in_prev,
  input  logic [31:`PCI_BASE_MATCH_LSB] base_register,
  input  logic                          target_memory_enable,
  output addr_phase_t                   addr_phase
);

  // Frame level one cycle back, used to spot the first cycle of FRAME
  logic frame_last;

  logic addr_phase_start;
  logic is_read_cmd;
  logic is_write_cmd;
  logic base_hit;
  logic ref_hit;

  // Registered reference, split into control and payload
  logic        valid_q;
  logic        is_read_q;
  logic        is_write_q;
  logic [31:0] address_q;
  logic [3:0]  command_q;

  // ==========================================================
  // Address phase detect and decode
  // ==========================================================

  // The address phase is the first cycle that FRAME is seen asserted
  assign addr_phase_start = pci_frame_in_prev & ~frame_last;

  // The sampled C/BE value carries the bus command directly
  // IO, config and special cycles fall into the default and are not claimed
  always_comb
  begin
    is_read_cmd  = 1'b0;
    is_write_cmd = 1'b0;
    case (pci_cbe_l_in_prev)
      `CMD_MEM_READ, `CMD_MEM_READ_MULTIPLE, `CMD_MEM_READ_LINE:
      begin
        is_read_cmd = 1'b1;
      end
      `CMD_MEM_WRITE, `CMD_MEM_WRITE_INVALIDATE:
      begin
        is_write_cmd = 1'b1;
      end
      default:
      begin
        is_read_cmd  = 1'b0;
        is_write_cmd = 1'b0;
      end
    endcase
  end

  // Only the upper address bits take part in the base compare
  assign base_hit = (pci_ad_in_prev[31:`PCI_BASE_MATCH_LSB] == base_register);

  // Memory space must be enabled for the target to claim anything
  assign ref_hit = addr_phase_start & target_memory_enable & base_hit
                   & (is_read_cmd | is_write_cmd);

  // ==========================================================
  // Output register
  // ==========================================================

  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      frame_last <= 1'b0;
      valid_q    <= 1'b0;
      is_read_q  <= 1'b0;
      is_write_q <= 1'b0;
    end
    else
    begin
      frame_last <= pci_frame_in_prev;
      // Valid is a single-cycle pulse, one per address phase at most
      valid_q    <= ref_hit;
      is_read_q  <= ref_hit & is_read_cmd;
      is_write_q <= ref_hit & is_write_cmd;
    end
  end

  // Address and command are only meaningful alongside valid
  always_ff @(posedge pci_clk)
  begin
    if (addr_phase_start)
    begin
      address_q <= pci_ad_in_prev;
      command_q <= pci_cbe_l_in_prev;
    end
  end

  always_comb
  begin
    addr_phase.valid    = valid_q;
    addr_phase.is_read  = is_read_q;
    addr_phase.is_write = is_write_q;
    addr_phase.address  = address_q;
    addr_phase.command  = command_q;
  end

  // A new address phase needs FRAME to drop first, so hits never come back to back
  a_valid_single_cycle : assert property (
    @(posedge pci_clk) disable iff (pci_reset_comb)
    addr_phase.valid |=> !addr_phase.valid
  );

  // A claimed reference is a read or a write, never both
  a_read_write_exclusive : assert property (
    @(posedge pci_clk) disable iff (pci_reset_comb)
    !(addr_phase.is_read && addr_phase.is_write)
  );

endmodule

`default_nettype wire

/* pci_target_pkg.sv */
// PCI target shared types: decoded reference, tracker events and response FIFO entry layout
`default_nettype none

package pci_target_pkg;

  // ==========================================================
  // Decoder to tracker and builder
  // ==========================================================

  // One memory reference that hit this target, held for one cycle
  typedef struct packed {
    logic        valid;
    logic        is_read;
    logic        is_write;
    logic [31:0] address;
    logic [3:0]  command;
  } addr_phase_t;

  // One-cycle events out of the delayed read tracker
  typedef struct packed {
    logic discarded;
    logic collision;
  } dr_event_t;

  // ==========================================================
  // Response FIFO word layouts
  // ==========================================================

  // Status report word, following the low half of the PCI status register layout
  // Bit 18 is a delayed read thrown away by the discard timer
  // Bit 17 asks the host to restart the delayed read after a colliding write
  // Bit 16 is an executed-address entry lost because the FIFO was full
  typedef struct packed {
    logic [12:0] reserved_hi;
    logic        read_discarded;
    logic        read_restart;
    logic        reference_lost;
    logic [15:0] reserved_lo;
  } status_bits_t;

  // The same data word is either a bus address or a status report,
  // depending on the entry type that travels with it
  typedef union packed {
    logic [31:0]  address;
    status_bits_t status;
  } response_data_u;

  // One response FIFO entry
  typedef struct packed {
    logic [3:0]     entry_type;
    logic [3:0]     cbe;
    response_data_u data;
  } response_entry_t;

endpackage

`default_nettype wire

/* pci_target_settings.svh */
// PCI target settings: base match, collision block, discard time and command/response codes
`ifndef PCI_TARGET_SETTINGS_SVH
`define PCI_TARGET_SETTINGS_SVH

// ==========================================================
// Address decode
// ==========================================================

// Lowest address bit compared against the base register, so a 16 MB window
`define PCI_BASE_MATCH_LSB 24

// Lowest address bit used in the write collision compare (128-byte prefetch block)
`define PCI_COLLISION_LSB 7

// Cycles a delayed read may wait for its retry before it is thrown away
`define TARGET_DISCARD_CYCLES 200

// ==========================================================
// PCI bus command codes, as seen on C/BE during the address phase
// ==========================================================
`define CMD_MEM_READ             4'h6
`define CMD_MEM_WRITE            4'h7
`define CMD_MEM_READ_MULTIPLE    4'hC
`define CMD_MEM_READ_LINE        4'hE
`define CMD_MEM_WRITE_INVALIDATE 4'hF

// Response FIFO entry types toward the host
`define RESPONSE_EXECUTED_ADDRESS 4'h1
`define RESPONSE_STATUS_REPORT    4'h2

`endif

/* pci_target_top.sv */
// PCI target address-phase top: decoder, delayed read tracker and response builder
`default_nettype none
`timescale 1ns/1ps
`include "pci_target_settings.svh"

module pci_target_top
  import pci_target_pkg::*;
(
  input  logic                          pci_clk,
  input  logic                          pci_reset_comb,
  // Registered PCI bus samples
  input  logic [31:0]                   pci_ad_in_prev,
  input  logic [3:0]                    pci_cbe_l_in_prev,
  input  logic                          pci_frame_in_prev,
  // Base address bits and memory space enable from the host
  input  logic [31:`PCI_BASE_MATCH_LSB] base_register,
  input  logic                          target_memory_enable,
  // Host response FIFO
  input  logic                          response_room_available,
  output response_entry_t               response_entry,
  output logic                          response_load,
  output logic                          delayed_read_in_progress
);

  // Decoded reference, shared by tracker and builder
  addr_phase_t addr_phase;

  // Delayed read end events toward the builder
  dr_event_t dr_event;

  // ==========================================================
  // Blocks
  // ==========================================================

  pci_address_decoder i_pci_address_decoder (
    .pci_clk              (pci_clk),
    .pci_reset_comb       (pci_reset_comb),
    .pci_frame_in_prev    (pci_frame_in_prev),
    .pci_ad_in_prev       (pci_ad_in_prev),
    .pci_cbe_l_in_prev    (pci_cbe_l_in_prev),
    .base_register        (base_register),
    .target_memory_enable (target_memory_enable),
    .addr_phase           (addr_phase)
  );

  delayed_read_tracker i_delayed_read_tracker (
    .pci_clk                  (pci_clk),
    .pci_reset_comb           (pci_reset_comb),
    .addr_phase               (addr_phase),
    .dr_event                 (dr_event),
    .delayed_read_in_progress (delayed_read_in_progress)
  );

  response_builder i_response_builder (
    .pci_clk                 (pci_clk),
    .pci_reset_comb          (pci_reset_comb),
    .addr_phase              (addr_phase),
    .dr_event                (dr_event),
    .response_room_available (response_room_available),
    .response_entry          (response_entry),
    .response_load           (response_load)
  );

endmodule

`default_nettype wire

/* response_builder.sv */
// Response builder: formats executed-address and status-report entries for the host FIFO
`default_nettype none
`timescale 1ns/1ps
`include "pci_target_settings.svh"

module response_builder
  import pci_target_pkg::*;
(
  input  logic            pci_clk,
  input  logic            pci_reset_comb,
  input  addr_phase_t     addr_phase,
  input  dr_event_t       dr_event,
  input  logic            response_room_available,
  output response_entry_t response_entry,
  output logic            response_load
);

  // Status bits waiting for a free slot, sticky until sent
  status_bits_t pending_bits;
  status_bits_t incoming_bits;
  status_bits_t pending_next;

  logic pending_any;
  logic send_address;
  logic send_status;
  logic reference_lost;

  response_entry_t entry_next;

  // ==========================================================
  // Slot arbitration
  // ==========================================================

  // Address entries have a fixed 2-cycle latency, so they go first
  assign send_address   = addr_phase.valid & response_room_available;
  assign reference_lost = addr_phase.valid & ~response_room_available;

  assign pending_any = |pending_bits;

  // Status goes out only in a slot no address entry wants
  assign send_status = ~addr_phase.valid & response_room_available & pending_any;

  // New status from this cycle lands in pending and rides the next free slot
  always_comb
  begin
    incoming_bits                = '0;
    incoming_bits.read_discarded = dr_event.discarded;
    incoming_bits.read_restart   = dr_event.collision;
    incoming_bits.reference_lost = reference_lost;
    if (send_status)
    begin
      pending_next = incoming_bits;
    end
    else
    begin
      pending_next = pending_bits | incoming_bits;
    end
  end

  // ==========================================================
  // Entry format
  // ==========================================================

  always_comb
  begin
    entry_next = '0;
    if (send_address)
    begin
      // Executed address carries the bus command in the C/BE field
      entry_next.entry_type   = `RESPONSE_EXECUTED_ADDRESS;
      entry_next.cbe          = addr_phase.command;
      entry_next.data.address = addr_phase.address;
    end
    else
    begin
      entry_next.entry_type  = `RESPONSE_STATUS_REPORT;
      entry_next.cbe         = 4'h0;
      entry_next.data.status = pending_bits;
    end
  end

  // ==========================================================
  // Registers
  // ==========================================================

  always_ff @(posedge pci_clk or posedge pci_reset_comb)
  begin
    if (pci_reset_comb)
    begin
      pending_bits  <= '0;
      response_load <= 1'b0;
    end
    else
    begin
      pending_bits  <= pending_next;
      response_load <= send_address | send_status;
    end
  end

  // Entry payload only matters while the load strobe is high
  always_ff @(posedge pci_clk)
  begin
    if (send_address | send_status)
    begin
      response_entry <= entry_next;
    end
  end

  // The strobe is registered, so the room it relied on was seen one cycle before
  a_load_needs_room : assert property (
    @(posedge pci_clk) disable iff (pci_reset_comb)
    response_load |-> $past(response_room_available)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the PCI target testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pci_target \
  -f compile.f -o sim_pci_target \
  && ./obj_dir/sim_pci_target | tee /dev/stderr | grep -q -F -x '*** PASSED ***' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb_pci_target.sv */
// PCI target testbench driving random bus traffic and checking it cycle by cycle against a model
`default_nettype none
`timescale 1ns/1ps
`include "pci_target_settings.svh"

module tb_pci_target
  import pci_target_pkg::*;
();

  localparam int ROOM_HIGH   = 0;
  localparam int ROOM_LOW    = 1;
  localparam int ROOM_RANDOM = 2;

  logic                          pci_clk;
  logic                          pci_reset_comb;
  logic [31:0]                   pci_ad_in_prev;
  logic [3:0]                    pci_cbe_l_in_prev;
  logic                          pci_frame_in_prev;
  logic [31:`PCI_BASE_MATCH_LSB] base_register;
  logic                          target_memory_enable;
  logic                          response_room_available;
  response_entry_t               response_entry;
  logic                          response_load;
  logic                          delayed_read_in_progress;

  // Reference model state
  logic                         m_frame_last;
  addr_phase_t                  m_ref;
  logic                         m_dr_active;
  logic [31:`PCI_COLLISION_LSB] m_dr_block;
  int unsigned                  m_dr_age;
  dr_event_t                    m_event;
  status_bits_t                 m_pending;
  logic                         m_load;
  response_entry_t              m_entry;

  logic [31:0] near_addr;
  int errors;
  int seen_address;
  int seen_lost;
  int seen_restart;
  int seen_discard;

  pci_target_top i_pci_target_top (
    .pci_clk                  (pci_clk),
    .pci_reset_comb           (pci_reset_comb),
    .pci_ad_in_prev           (pci_ad_in_prev),
    .pci_cbe_l_in_prev        (pci_cbe_l_in_prev),
    .pci_frame_in_prev        (pci_frame_in_prev),
    .base_register            (base_register),
    .target_memory_enable     (target_memory_enable),
    .response_room_available  (response_room_available),
    .response_entry           (response_entry),
    .response_load            (response_load),
    .delayed_read_in_progress (delayed_read_in_progress)
  );

  initial
  begin
    pci_clk = 1'b0;
    forever
    begin
      #50 pci_clk = ~pci_clk;
    end
  end

  // ==========================================================
  // Reference model, advanced once per rising clock edge
  // ==========================================================

  task automatic model_clock_edge();
    addr_phase_t                  ref_next;
    dr_event_t                    event_next;
    status_bits_t                 incoming;
    logic                         is_rd;
    logic                         is_wr;
    logic                         collide;
    logic [31:`PCI_COLLISION_LSB] wr_block;
    logic [31:`PCI_COLLISION_LSB] next_block;
    // A claimed reference shows up one edge after the first FRAME cycle
    is_rd = pci_cbe_l_in_prev inside {`CMD_MEM_READ, `CMD_MEM_READ_MULTIPLE, `CMD_MEM_READ_LINE};
    is_wr = pci_cbe_l_in_prev inside {`CMD_MEM_WRITE, `CMD_MEM_WRITE_INVALIDATE};
    ref_next          = '0;
    ref_next.valid    = pci_frame_in_prev & ~m_frame_last & target_memory_enable & (is_rd | is_wr)
                        & (pci_ad_in_prev[31:`PCI_BASE_MATCH_LSB] == base_register);
    ref_next.is_read  = ref_next.valid & is_rd;
    ref_next.is_write = ref_next.valid & is_wr;
    ref_next.address  = pci_ad_in_prev;
    ref_next.command  = pci_cbe_l_in_prev;
    // A write into the read's block or the one after it ends the delayed read
    wr_block   = m_ref.address[31:`PCI_COLLISION_LSB];
    next_block = m_dr_block + 1'b1;
    collide    = m_ref.valid & m_ref.is_write & m_dr_active
                 & ((wr_block == m_dr_block) | (wr_block == next_block));
    event_next.collision = collide;
    // In-progress stays up for the whole discard interval
    event_next.discarded = m_dr_active & ~collide & (m_dr_age == `TARGET_DISCARD_CYCLES - 1);
    if (m_ref.valid && m_ref.is_read && !m_dr_active)
    begin
      m_dr_active = 1'b1;
      m_dr_age    = 0;
      m_dr_block  = m_ref.address[31:`PCI_COLLISION_LSB];
    end
    else if (collide || event_next.discarded)
    begin
      m_dr_active = 1'b0;
    end
    else if (m_dr_active)
    begin
      m_dr_age++;
    end
    // Address entries go first and sticky status rides the first free slot
    incoming                = '0;
    incoming.read_discarded = m_event.discarded;
    incoming.read_restart   = m_event.collision;
    incoming.reference_lost = m_ref.valid & ~response_room_available;
    m_load  = 1'b0;
    m_entry = '0;
    if (m_ref.valid && response_room_available)
    begin
      m_load               = 1'b1;
      m_entry.entry_type   = `RESPONSE_EXECUTED_ADDRESS;
      m_entry.cbe          = m_ref.command;
      m_entry.data.address = m_ref.address;
      m_pending            = m_pending | incoming;
    end
    else if (response_room_available && (m_pending != '0))
    begin
      m_load              = 1'b1;
      m_entry.entry_type  = `RESPONSE_STATUS_REPORT;
      m_entry.data.status = m_pending;
      m_pending           = incoming;
    end
    else
    begin
      m_pending = m_pending | incoming;
    end
    m_event      = event_next;
    m_ref        = ref_next;
    m_frame_last = pci_frame_in_prev;
  endtask

  // ==========================================================
  // Bus driving and checks
  // ==========================================================

  // Counts each entry the DUT loads by its kind
  task automatic tally_entry(input response_entry_t entry);
    if (entry.entry_type == `RESPONSE_EXECUTED_ADDRESS)
    begin
      seen_address++;
    end
    else if (entry.entry_type == `RESPONSE_STATUS_REPORT)
    begin
      seen_lost    += int'(entry.data.status.reference_lost);
      seen_restart += int'(entry.data.status.read_restart);
      seen_discard += int'(entry.data.status.read_discarded);
    end
  endtask

  // Drives one cycle from a falling edge and checks the outputs at the next one
  task automatic bus_cycle(input logic frame, input logic [31:0] ad, input logic [3:0] cbe,
                           input logic room);
    pci_frame_in_prev       = frame;
    pci_ad_in_prev          = ad;
    pci_cbe_l_in_prev       = cbe;
    response_room_available = room;
    @(posedge pci_clk);
    model_clock_edge();
    @(negedge pci_clk);
    assert (response_load === m_load)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: response_load is %b, expected %b", $time, response_load, m_load);
    end
    if (m_load)
    begin
      assert (response_entry === m_entry)
      else
      begin
        errors++;
        $display("[FAIL] %0t ns: entry is %h, expected %h", $time, response_entry, m_entry);
      end
    end
    assert (delayed_read_in_progress === m_dr_active)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: delayed_read_in_progress is %b, expected %b", $time,
               delayed_read_in_progress, m_dr_active);
    end
    if (response_load === 1'b1)
    begin
      tally_entry(response_entry);
    end
  endtask

  function automatic logic pick_room(input int mode);
    if (mode == ROOM_RANDOM)
    begin
      return $urandom_range(7) != 0;
    end
    return mode == ROOM_HIGH;
  endfunction

  // One address phase with FRAME held one to three cycles and at least 3 idle cycles after it
  task automatic transaction(input logic [3:0] cmd, input logic [31:0] addr, input int mode);
    int frame_len;
    int span;
    int i;
    frame_len = 1 + $urandom_range(2);
    span      = frame_len + 3 + $urandom_range(3);
    for (i = 0; i < span; i++)
    begin
      // Only the first FRAME cycle carries the command and address
      bus_cycle(i < frame_len, (i == 0) ? addr : $urandom(),
                (i == 0) ? cmd : 4'($urandom()), pick_room(mode));
    end
  endtask

  task automatic wait_read_idle(input int limit);
    int count;
    count = 0;
    while (delayed_read_in_progress && count < limit)
    begin
      bus_cycle(1'b0, 32'h0, 4'h0, 1'b1);
      count++;
    end
    if (delayed_read_in_progress)
    begin
      errors++;
      $display("Timeout: delayed read still in progress after %0d cycles", limit);
    end
    repeat (4) bus_cycle(1'b0, 32'h0, 4'h0, 1'b1);
  endtask

  function automatic logic [31:0] hit(input logic [23:0] low);
    return {base_register, low};
  endfunction

  // Random command and address with a bias toward hits near the last read
  task automatic random_transaction();
    logic [3:0]  cmd;
    logic [31:0] addr;
    case ($urandom_range(6))
      0: cmd = `CMD_MEM_READ;
      1: cmd = `CMD_MEM_WRITE;
      2: cmd = `CMD_MEM_READ_MULTIPLE;
      3: cmd = `CMD_MEM_READ_LINE;
      4: cmd = `CMD_MEM_WRITE_INVALIDATE;
      default: cmd = 4'($urandom());
    endcase
    addr = hit(24'($urandom()));
    if ($urandom_range(2) == 0)
    begin
      addr = near_addr + 32'($urandom_range(383)) - 32'd128;
    end
    if ($urandom_range(7) == 0)
    begin
      addr[31:24] = 8'($urandom());
    end
    if (cmd inside {`CMD_MEM_READ, `CMD_MEM_READ_MULTIPLE, `CMD_MEM_READ_LINE})
    begin
      near_addr = addr;
    end
    target_memory_enable = ($urandom_range(15) != 0);
    transaction(cmd, addr, ROOM_RANDOM);
  endtask

  initial
  begin
    int n;
    pci_reset_comb          = 1'b1;
    pci_frame_in_prev       = 1'b0;
    pci_ad_in_prev          = '0;
    pci_cbe_l_in_prev       = '0;
    base_register           = '0;
    target_memory_enable    = 1'b1;
    response_room_available = 1'b1;
    {m_frame_last, m_ref, m_dr_active, m_dr_block, m_event, m_pending, m_load} = '0;
    m_dr_age = 0;
    errors = 0;
    {seen_address, seen_lost, seen_restart, seen_discard} = '0;
    void'($urandom(16862));
    base_register = 8'($urandom());
    near_addr     = hit(24'h001000);
    repeat (16) @(posedge pci_clk);
    @(negedge pci_clk);
    pci_reset_comb = 1'b0;

    // Hit, miss, non-memory command and disabled memory space
    transaction(`CMD_MEM_WRITE, hit(24'h000104), ROOM_HIGH);
    transaction(`CMD_MEM_WRITE_INVALIDATE, {~base_register, 24'h000200}, ROOM_HIGH);
    transaction(4'h3, hit(24'h000300), ROOM_HIGH);
    target_memory_enable = 1'b0;
    transaction(`CMD_MEM_READ, hit(24'h000400), ROOM_HIGH);
    target_memory_enable = 1'b1;
    // Discard by timeout, with a second read that must not restart the timer
    transaction(`CMD_MEM_READ, hit(24'h001000), ROOM_HIGH);
    transaction(`CMD_MEM_READ_MULTIPLE, hit(24'h008000), ROOM_HIGH);
    wait_read_idle(400);
    // A write two blocks away is harmless but one into the next block collides
    transaction(`CMD_MEM_READ_LINE, hit(24'h004000), ROOM_HIGH);
    transaction(`CMD_MEM_WRITE, hit(24'h004100), ROOM_HIGH);
    transaction(`CMD_MEM_WRITE, hit(24'h004084), ROOM_HIGH);
    wait_read_idle(400);
    transaction(`CMD_MEM_READ, hit(24'h005000), ROOM_HIGH);
    transaction(`CMD_MEM_WRITE_INVALIDATE, hit(24'h005010), ROOM_HIGH);
    wait_read_idle(400);
    // No room during a read, so its entry is lost and reported later
    transaction(`CMD_MEM_READ, hit(24'h006000), ROOM_LOW);
    wait_read_idle(400);

    for (n = 0; n < 400; n++)
    begin
      random_transaction();
    end
    target_memory_enable = 1'b1;
    wait_read_idle(400);

    assert (seen_address > 0 && seen_lost > 0 && seen_restart > 0 && seen_discard > 0)
    else
    begin
      errors++;
      $display("The DUT never loaded every kind of response entry");
    end
    $display("Done: %0d errors, %0d address, %0d lost, %0d restart, %0d discard entries",
             errors, seen_address, seen_lost, seen_restart, seen_discard);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
